// File: src.f
+incdir+hw
hw/csi_rx_pkg.sv
hw/csi_rx_hdr_ecc.sv
hw/csi_rx_word_aligner.sv
hw/csi_rx_packet_handler.sv
hw/csi_rx_top.sv
verif/csi_rx_sva.sv
verif/csi_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the receiver testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module csi_rx_tb \
   -o csi_rx_sim \
   && ./obj_dir/csi_rx_sim | tee /dev/stderr | grep -q "^Everything OK$" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verif/csi_rx_tb.sv
// csi-2 receiver testbench
`include "csi_rx_consts.svh"
`default_nettype none
`timescale 1ns/100ps

module csi_rx_tb;

   localparam int n_pairs   = 3;                          // unskewed and skewed twins
   localparam int rand_wc   = 20;                         // bytes in each twin packet
   localparam int pkt_count = 6 + 2 * n_pairs;
   // sync, two header bytes and the trailer on each lane for every packet
   // payload is split over two lanes
   localparam int lane_bytes  = (3 + `CSI_MAX_SKEW) * pkt_count + 16 / 2 + 8 / 2 +
                                2 * n_pairs * (rand_wc / 2);
   localparam int cycle_limit = 16 + lane_bytes + 40 * pkt_count;

   logic                       reset;          // dut clock
   logic                       clock;          // dut async reset
   logic                       enable;
   csi_rx_pkg::lane_in_t       lanes;
   csi_rx_pkg::payload_t       payload;
   csi_rx_pkg::link_status_t   status;
   logic                       packet_done;

   csi_rx_pkg::byte_t   tx_data [$];           // payload bytes of the next packet
   csi_rx_pkg::word_t   exp_words [$];         // payload words still owed by the dut
   csi_rx_pkg::word_t   exp_word;
   logic                exp_in_frame;
   logic                exp_ecc_ok;
   logic                exp_hdr_ok;
   logic                line_check;            // in_line must be low after packet_done
   int                  done_count;
   int                  value_errors;
   int                  other_errors;
   int                  cycles;

   csi_rx_top dut_i (
      .reset       (reset),
      .clock       (clock),
      .enable      (enable),
      .lanes       (lanes),
      .payload     (payload),
      .status      (status),
      .packet_done (packet_done)
   );

   bind csi_rx_packet_handler csi_rx_sva sva_i (
      .reset       (reset),
      .clock       (clock),
      .sync_wait   (sync_wait),
      .packet_done (packet_done),
      .payload     (payload),
      .status      (status)
   );

   initial begin
      reset = 1'b0;
      forever #50 reset = ~reset;               // 100 ns period
   end

   // ------------------------------
   // reference model
   function automatic csi_rx_pkg::ecc_t expected_ecc(input logic [23:0] d);
      logic [5:0][23:0]   masks;
      csi_rx_pkg::ecc_t   e;
      masks = {`CSI_ECC_MASK5, `CSI_ECC_MASK4, `CSI_ECC_MASK3,
               `CSI_ECC_MASK2, `CSI_ECC_MASK1, `CSI_ECC_MASK0};
      e = '0;                                   // bits 7:6 stay zero
      for (int b = 0; b < 6; b++) begin
         e[b] = ^(d & masks[b]);
      end
      return e;
   endfunction

   function automatic logic header_allowed(input logic [7:0] di);
      return (di[7:6] == 2'b00) &&
             (di[5:0] inside {[6'h00:6'h03], [6'h10:6'h12], [6'h28:6'h2D]});
   endfunction

   task automatic fill_payload(input int n);
      tx_data.delete();
      for (int i = 0; i < n; i++) begin
         tx_data.push_back(8'($urandom));
      end
   endtask

   // one packet on both lanes
   // lane 0 takes the even bytes and the late lane lags by skew cycles
   task automatic send_packet(input logic [7:0] di, input logic [15:0] wc,
                              input logic [7:0] ecc_flip, input int skew,
                              input logic lane1_late);
      csi_rx_pkg::byte_t  b0 [$];
      csi_rx_pkg::byte_t  b1 [$];
      csi_rx_pkg::ecc_t   ecc_ref;
      int                 d0;
      int                 d1;
      int                 start_done;
      ecc_ref    = expected_ecc({wc, di});
      exp_hdr_ok = header_allowed(di);
      exp_ecc_ok = ((ecc_ref ^ ecc_flip) == ecc_ref);
      if (exp_hdr_ok && (di[5:0] == `CSI_DT_FS)) begin
         exp_in_frame = 1'b1;
      end else if (exp_hdr_ok && (di[5:0] == `CSI_DT_FE)) begin
         exp_in_frame = 1'b0;
      end
      b0.push_back(`CSI_SYNC_BYTE);
      b1.push_back(`CSI_SYNC_BYTE);
      b0.push_back(di);
      b1.push_back(wc[7:0]);
      b0.push_back(wc[15:8]);
      b1.push_back(ecc_ref ^ ecc_flip);
      if (exp_hdr_ok && (di[5:0] > 6'h0F)) begin
         for (int i = 0; i + 1 < int'(wc); i += 2) begin
            b0.push_back(tx_data[i]);
            b1.push_back(tx_data[i+1]);
            exp_words.push_back({tx_data[i+1], tx_data[i]});   // lane 1 upper
         end
      end
      // trailer keeps the early lane shifting until the late one is through
      for (int i = 0; i < `CSI_MAX_SKEW; i++) begin
         b0.push_back(8'h00);
         b1.push_back(8'h00);
      end
      d0 = lane1_late ? 0 : skew;
      d1 = lane1_late ? skew : 0;
      start_done = done_count;
      for (int t = 0; t <= b0.size() + skew; t++) begin
         @(posedge reset);
         #10;
         lanes = '0;                            // idle unless a byte is due
         if ((t >= d0) && (t - d0 < b0.size())) begin
            lanes.lane0       = b0[t-d0];
            lanes.lane0_valid = 1'b1;
         end
         if ((t >= d1) && (t - d1 < b1.size())) begin
            lanes.lane1       = b1[t-d1];
            lanes.lane1_valid = 1'b1;
         end
      end
      while (done_count == start_done) begin
         @(posedge reset);
      end
      repeat (4) @(posedge reset);              // handler back in START
   endtask

   // ------------------------------
   // checker samples mid-cycle
   always @(negedge reset) begin
      if (!clock) begin
         if (line_check) begin
            assert (status.in_line == 1'b0) else begin
               $display("error status.in_line got %h expected %h", status.in_line, 1'b0);
               value_errors++;
            end
         end
         line_check = packet_done;
         if (payload.valid) begin
            assert (status.in_line) else begin
               $display("error status.in_line got %h expected %h", status.in_line, 1'b1);
               value_errors++;
            end
            if (exp_words.size() == 0) begin
               $display("payload word %h arrived when none was expected", payload.data);
               other_errors++;
            end else begin
               exp_word = exp_words.pop_front();
               assert (payload.data == exp_word) else begin
                  $display("error payload.data got %h expected %h", payload.data, exp_word);
                  value_errors++;
               end
            end
         end
         if (packet_done) begin
            done_count++;
            assert (exp_words.size() == 0) else begin
               $display("packet ended with %0d payload words missing", exp_words.size());
               other_errors++;
            end
            exp_words.delete();
            assert (status.ecc_ok == exp_ecc_ok) else begin
               $display("error status.ecc_ok got %h expected %h", status.ecc_ok, exp_ecc_ok);
               value_errors++;
            end
            assert (status.hdr_ok == exp_hdr_ok) else begin
               $display("error status.hdr_ok got %h expected %h", status.hdr_ok, exp_hdr_ok);
               value_errors++;
            end
            assert (status.in_frame == exp_in_frame) else begin
               $display("error status.in_frame got %h expected %h",
                        status.in_frame, exp_in_frame);
               value_errors++;
            end
         end
      end
   end

   // ------------------------------
   // run limit
   initial begin
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge reset);
         cycles++;
      end
      $display("timeout after %0d cycles, a packet never finished", cycles);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("Something failed");
      $finish;
   end

   // ------------------------------
   // main sequence
   initial begin
      void'($urandom(35));
      clock        = 1'b1;                      // reset held from time zero
      enable       = 1'b0;
      lanes        = '0;
      exp_in_frame = 1'b0;
      exp_ecc_ok   = 1'b0;
      exp_hdr_ok   = 1'b0;
      line_check   = 1'b0;
      done_count   = 0;
      value_errors = 0;
      other_errors = 0;
      repeat (16) @(posedge reset);
      #10;
      clock  = 1'b0;
      enable = 1'b1;
      repeat (2) @(posedge reset);

      send_packet(8'h00, 16'd0, 8'h00, 0, 1'b0);            // frame start
      fill_payload(16);
      send_packet(8'h2A, 16'd16, 8'h00, 0, 1'b0);           // raw8 line
      fill_payload(8);
      send_packet(8'h2A, 16'd8, 8'h04, 0, 1'b0);            // one ecc bit flipped
      for (int p = 0; p < n_pairs; p++) begin
         fill_payload(rand_wc);
         send_packet(8'h2A, 16'(rand_wc), 8'h00, 0, 1'b0);
         send_packet(8'h2A, 16'(rand_wc), 8'h00, int'($urandom_range(2, 0)),
                     1'($urandom_range(1, 0)));
      end
      send_packet(8'h05, 16'd0, 8'h00, 0, 1'b0);            // type not allowed
      send_packet(8'hEA, 16'd8, 8'h00, 1, 1'b1);            // reserved bits set
      send_packet(8'h01, 16'd0, 8'h00, 0, 1'b0);            // frame end

      repeat (2) @(posedge reset);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      if ((value_errors == 0) && (other_errors == 0)) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/csi_rx_sva.sv
// packet handler assertions
`default_nettype none
`timescale 1ns/100ps

module csi_rx_sva (
   input wire logic                      reset,        // clock
   input wire logic                      clock,        // async reset, active high
   input wire logic                      sync_wait,
   input wire logic                      packet_done,
   input wire csi_rx_pkg::payload_t      payload,
   input wire csi_rx_pkg::link_status_t  status
);

   // ------------------------------
   // packet end strobe is a single pulse
   done_pulse: assert property (@(posedge reset) disable iff (clock)
      packet_done |=> !packet_done)
      else $error("packet_done stayed high for more than one cycle");

   // payload only flows inside a line packet
   payload_in_line: assert property (@(posedge reset) disable iff (clock)
      payload.valid |-> status.in_line)
      else $error("payload word seen while in_line is low");

   // handler never hunts for sync while it is reading payload
   hunt_or_read: assert property (@(posedge reset) disable iff (clock)
      !(sync_wait && payload.valid))
      else $error("sync_wait and payload.valid high in the same cycle");

endmodule

`default_nettype wire

// File: hw/csi_rx_top.sv
// csi-2 two-lane receiver top
`default_nettype none
`timescale 1ns/100ps

module csi_rx_top (
   input  wire logic                    reset,        // clock
   input  wire logic                    clock,        // async reset, active high
   input  wire logic                    enable,
   input  wire csi_rx_pkg::lane_in_t    lanes,        // byte-aligned lanes
   output csi_rx_pkg::payload_t         payload,      // two bytes per cycle
   output csi_rx_pkg::link_status_t     status,
   output logic                         packet_done   // one cycle per packet
);

   csi_rx_pkg::word_t   word;         // deskewed lane word
   logic                word_valid;
   logic                sync_wait;    // handler idle in START

   // ------------------------------
   // lane deskew
   csi_rx_word_aligner aligner_i (
      .reset       (reset),
      .clock       (clock),
      .enable      (enable),
      .lanes       (lanes),
      .sync_wait   (sync_wait),
      .packet_done (packet_done),
      .word        (word),
      .word_valid  (word_valid)
   );

   // ------------------------------
   // header parse and payload
   csi_rx_packet_handler handler_i (
      .reset       (reset),
      .clock       (clock),
      .enable      (enable),
      .word        (word),
      .word_valid  (word_valid),
      .sync_wait   (sync_wait),
      .packet_done (packet_done),   // also rearms the aligner
      .payload     (payload),
      .status      (status)
   );

endmodule

`default_nettype wire

// File: hw/csi_rx_packet_handler.sv
// csi-2 packet handler
`include "csi_rx_consts.svh"
`default_nettype none
`timescale 1ns/100ps

module csi_rx_packet_handler (
   input  wire logic                    reset,        // clock
   input  wire logic                    clock,        // async reset, active high
   input  wire logic                    enable,
   input  wire csi_rx_pkg::word_t       word,         // aligned word from aligner
   input  wire logic                    word_valid,
   output logic                         sync_wait,    // aligner may hunt for sync
   output logic                         packet_done,  // one cycle at packet end
   output csi_rx_pkg::payload_t         payload,      // long packet payload
   output csi_rx_pkg::link_status_t     status
);

   csi_rx_pkg::pkt_state_t   state;
   csi_rx_pkg::hdr_t         shift_q;       // last two words with newest on top
   csi_rx_pkg::hdr_t         hdr;           // full header as seen in SYNC1
   csi_rx_pkg::data_type_t   data_type;
   csi_rx_pkg::ecc_t         ecc_calc;      // ecc expected for this header
   logic [15:0]              word_count;    // byte count of a long packet
   logic [15:0]              len_q;         // word count kept for LONG_READ
   logic [15:0]              bytes_read;
   logic [16:0]              next_read;     // one bit wider so it never wraps
   logic                     type_allowed;
   logic                     hdr_valid;
   logic                     long_pkt;
   logic                     is_hdr;        // header complete this cycle
   logic                     in_pkt;        // states that keep in_line alive

   // ------------------------------
   // header decode
   always_comb begin
      // second header word is still on the input in SYNC1
      hdr          = {word, shift_q[31:16]};
      data_type    = hdr[5:0];
      word_count   = hdr[23:8];

      type_allowed = data_type inside {
         6'h00, 6'h01, 6'h02, 6'h03,                   // frame and line sync
         6'h10, 6'h11, 6'h12,                          // non-image data
         6'h28, 6'h29, 6'h2A, 6'h2B, 6'h2C, 6'h2D      // raw formats
      };
      hdr_valid    = type_allowed && (hdr[7:6] == 2'b00);   // virtual channel 0 only
      long_pkt     = hdr_valid && (data_type > 6'h0F);

      is_hdr       = word_valid && (state == csi_rx_pkg::SYNC1);
      in_pkt       = state inside {csi_rx_pkg::SYNC0, csi_rx_pkg::SYNC1,
                                   csi_rx_pkg::LONG_WAIT, csi_rx_pkg::LONG_READ};
      next_read    = {1'b0, bytes_read} + 17'd2;
   end

   csi_rx_hdr_ecc ecc_i (
      .data (hdr[23:0]),
      .ecc  (ecc_calc)
   );

   // words shift in every enabled cycle
   always_ff @(posedge reset) begin
      if (enable) begin
         shift_q <= {word, shift_q[31:16]};
      end
   end

   // ------------------------------
   // packet fsm
   always_ff @(posedge reset or posedge clock) begin
      if (clock) begin
         state      <= csi_rx_pkg::INIT;
         bytes_read <= '0;
         len_q      <= '0;
      end else if (enable) begin
         unique case (state)
            csi_rx_pkg::INIT: begin
               state <= csi_rx_pkg::START;              // one idle cycle
            end
            csi_rx_pkg::START: begin
               bytes_read <= '0;
               if (word_valid) begin
                  state <= csi_rx_pkg::SYNC0;           // sync word b8b8 seen
               end
            end
            csi_rx_pkg::SYNC0: begin
               state <= csi_rx_pkg::SYNC1;              // first header word arrives
            end
            csi_rx_pkg::SYNC1: begin
               len_q <= word_count;
               if (long_pkt) begin
                  state <= csi_rx_pkg::LONG_WAIT;       // first payload word on its way
               end else begin
                  state <= csi_rx_pkg::DONE;
               end
            end
            csi_rx_pkg::LONG_WAIT: begin
               state <= csi_rx_pkg::LONG_READ;
            end
            csi_rx_pkg::LONG_READ: begin
               // two bytes per cycle until count or guard is hit
               if ((next_read < {1'b0, len_q}) && (next_read < `CSI_MAX_LONG_BYTES)) begin
                  bytes_read <= next_read[15:0];
               end else begin
                  state <= csi_rx_pkg::DONE;
               end
            end
            csi_rx_pkg::DONE: begin
               state <= csi_rx_pkg::STOP;               // packet_done high here
            end
            csi_rx_pkg::STOP: begin
               state <= csi_rx_pkg::START;
            end
            default: begin
               state <= csi_rx_pkg::INIT;
            end
         endcase
      end
   end

   // ------------------------------
   // link status
   always_ff @(posedge reset or posedge clock) begin
      if (clock) begin
         status <= '0;
      end else if (enable) begin
         if (is_hdr) begin
            status.ecc_ok <= (hdr[31:24] == ecc_calc);
            status.hdr_ok <= hdr_valid;
            if (hdr_valid && (data_type == `CSI_DT_FS)) begin
               status.in_frame <= 1'b1;
            end else if (hdr_valid && (data_type == `CSI_DT_FE)) begin
               status.in_frame <= 1'b0;
            end
         end

         // any valid 2x type opens a line
         if (is_hdr && hdr_valid && (data_type[5:4] == 2'b10)) begin
            status.in_line <= 1'b1;
         end else if (!in_pkt) begin
            status.in_line <= 1'b0;                     // closes in DONE at the latest
         end
      end
   end

   // ------------------------------
   // outputs straight from the state
   always_comb begin
      sync_wait     = (state == csi_rx_pkg::START);
      packet_done   = (state == csi_rx_pkg::DONE);
      payload.valid = (state == csi_rx_pkg::LONG_READ);
      payload.data  = payload.valid ? shift_q[31:16] : '0;   // zero outside payload
   end

endmodule

`default_nettype wire

// File: hw/csi_rx_word_aligner.sv
// two-lane word aligner
`include "csi_rx_consts.svh"
`default_nettype none
`timescale 1ns/100ps

module csi_rx_word_aligner (
   input  wire logic                  reset,        // clock
   input  wire logic                  clock,        // async reset, active high
   input  wire logic                  enable,
   input  wire csi_rx_pkg::lane_in_t  lanes,        // byte-aligned lane bytes
   input  wire logic                  sync_wait,    // handler waits for a packet
   input  wire logic                  packet_done,  // handler finished the packet
   output csi_rx_pkg::word_t          word,         // deskewed word
   output logic                       word_valid
);

   csi_rx_pkg::align_state_t   state;
   csi_rx_pkg::byte_t          lane_byte  [2];                     // lane bytes as array
   logic                       lane_valid [2];
   csi_rx_pkg::byte_t          line [2][(`CSI_MAX_SKEW)+1];        // newest byte at 0
   logic [$clog2((`CSI_MAX_SKEW)+1)-1:0] tap [2];                  // bytes since sync
   logic [1:0]                 latched;                            // lane saw its sync byte
   logic                       both_latched;

   // fold the lane struct into arrays so both lanes share one loop
   always_comb begin
      lane_byte[0]  = lanes.lane0;
      lane_byte[1]  = lanes.lane1;
      lane_valid[0] = lanes.lane0_valid;
      lane_valid[1] = lanes.lane1_valid;
   end

   assign both_latched = &latched;

   // ------------------------------
   // sync hunt and lock
   always_ff @(posedge reset or posedge clock) begin
      if (clock) begin
         state      <= csi_rx_pkg::HUNT;
         latched    <= '0;
         tap        <= '{default: '0};
         word_valid <= 1'b0;
      end else if (enable) begin
         if (packet_done) begin
            state      <= csi_rx_pkg::HUNT;      // rearm for next packet
            latched    <= '0;
            word_valid <= 1'b0;
         end else if (state == csi_rx_pkg::HUNT) begin
            if (both_latched) begin
               // taps now point at the two sync bytes
               state      <= csi_rx_pkg::LOCKED;
               word_valid <= 1'b1;
            end else begin
               for (int i = 0; i < 2; i++) begin
                  if (lane_valid[i]) begin
                     if (!latched[i] && sync_wait && (lane_byte[i] == `CSI_SYNC_BYTE)) begin
                        latched[i] <= 1'b1;
                        tap[i]     <= '0;        // sync byte sits at line[0]
                     end else if (latched[i] && (tap[i] != (`CSI_MAX_SKEW))) begin
                        tap[i]     <= tap[i] + 1'b1;   // sync byte moves one deeper
                     end
                  end
               end
            end
         end
      end
   end

   // ------------------------------
   // deskew lines and word output
   // the taps freeze at lock so both lanes stay in step
   always_ff @(posedge reset) begin
      if (enable) begin
         for (int i = 0; i < 2; i++) begin
            if (lane_valid[i]) begin
               line[i][0] <= lane_byte[i];
               for (int k = 1; k <= (`CSI_MAX_SKEW); k++) begin
                  line[i][k] <= line[i][k-1];
               end
            end
         end
         word <= {line[1][tap[1]], line[0][tap[0]]};  // lane 1 upper
      end
   end

endmodule

`default_nettype wire

// File: hw/csi_rx_hdr_ecc.sv
// packet header ecc
`include "csi_rx_consts.svh"
`default_nettype none
`timescale 1ns/100ps

module csi_rx_hdr_ecc (
   input  wire logic [23:0]     data,   // word count and data id
   output csi_rx_pkg::ecc_t     ecc     // expected ecc byte
);

   // ------------------------------
   // hamming parity
   // each bit covers the header bits set in its mask
   always_comb begin
      ecc[7:6] = 2'b00;                               // unused in csi-2

      // p0 over d0 d1 d2 d4 d5 d7 d10 d11 d13 d16 d20..d23
      ecc[0]   = ^(data & `CSI_ECC_MASK0);

      // p1 over d0 d1 d3 d4 d6 d8 d10 d12 d14 d17 d20..d23
      ecc[1]   = ^(data & `CSI_ECC_MASK1);

      // p2 over d0 d2 d3 d5 d6 d9 d11 d12 d15 d18 d20..d22
      ecc[2]   = ^(data & `CSI_ECC_MASK2);

      // p3 over d1..d3 d7..d9 d13..d15 d19 d20 d21 d23
      ecc[3]   = ^(data & `CSI_ECC_MASK3);

      // p4 over d4..d9 d16..d20 d22 d23
      ecc[4]   = ^(data & `CSI_ECC_MASK4);

      // p5 over d10..d19 d21..d23
      ecc[5]   = ^(data & `CSI_ECC_MASK5);
   end

   // a single flipped header bit gives a nonzero syndrome
   // when the received byte is xored with this one

endmodule

`default_nettype wire

// File: hw/csi_rx_pkg.sv
// csi-2 receiver types
`default_nettype none

package csi_rx_pkg;

   typedef logic [7:0]  byte_t;       // one lane byte
   typedef logic [15:0] word_t;       // lane 1 in the upper byte
   typedef logic [31:0] hdr_t;        // {ecc, word count, data id}
   typedef logic [5:0]  data_type_t;
   typedef logic [7:0]  ecc_t;        // top two bits always zero

   // raw lane input
   typedef struct packed {
      byte_t lane0;
      byte_t lane1;
      logic  lane0_valid;
      logic  lane1_valid;
   } lane_in_t;

   typedef struct packed {
      word_t data;                    // two payload bytes
      logic  valid;
   } payload_t;

   // link state as seen from the last header
   typedef struct packed {
      logic in_frame;                 // between fs and fe
      logic in_line;                  // receiving a line packet
      logic ecc_ok;                   // last header ecc matched
      logic hdr_ok;                   // last header type and reserved bits sane
   } link_status_t;

   typedef enum logic [2:0] {
      INIT,
      START,
      SYNC0,
      SYNC1,
      LONG_WAIT,
      LONG_READ,
      DONE,
      STOP
   } pkt_state_t;

   typedef enum logic {
      HUNT,
      LOCKED
   } align_state_t;

endpackage

`default_nettype wire

// File: hw/csi_rx_consts.svh
// csi-2 receiver constants
`default_nettype none

`ifndef CSI_RX_CONSTS_SVH
`define CSI_RX_CONSTS_SVH

// ------------------------------
// lane framing
`define CSI_SYNC_BYTE       8'hB8   // leader byte on every lane
`define CSI_MAX_SKEW        2       // worst lane skew in cycles
`define CSI_MAX_LONG_BYTES  8192    // read guard for one long packet

// short packet data types
`define CSI_DT_FS           6'h00   // frame start
`define CSI_DT_FE           6'h01   // frame end

// ------------------------------
// header ecc parity masks over the 24 header bits
`define CSI_ECC_MASK0       24'hF12CB7
`define CSI_ECC_MASK1       24'hF2555B
`define CSI_ECC_MASK2       24'h749A6D
`define CSI_ECC_MASK3       24'hB8E38E
`define CSI_ECC_MASK4       24'hDF03F0
`define CSI_ECC_MASK5       24'hEFFC00

`endif

`default_nettype wire
